/* source/commit_trace_pkg.sv */
// commit trace shared types
`default_nettype none

package commit_trace_pkg;

   // architectural widths, fixed by the instruction set
   localparam int DATA_W = 32;                  // register data width
   localparam int REG_AW = 5;                   // register address width
   localparam int PC_W   = 30;                  // word pc, byte pc without bits 1:0
   localparam int SEQ_W  = 16;                  // commit sequence number, wraps

   // one writeback slot as presented by the core, 69 bits
   typedef struct packed
   {
      logic              valid;                 // slot holds an instruction
      logic              rd_we;                 // instruction writes a register
      logic [REG_AW-1:0] rd_addr;               // destination register
      logic [DATA_W-1:0] dout;                  // result value
      logic [PC_W-1:0]   pc;                    // word pc of the instruction
   } wb_slot_t;

   // one commit-trace record, 83 bits
   typedef struct packed
   {
      logic [SEQ_W-1:0]  seq;                   // running commit number
      logic [PC_W-1:0]   pc;                    // word pc
      logic [REG_AW-1:0] rd_addr;               // destination register
      logic [DATA_W-1:0] dout;                  // written value
   } trace_rec_t;

endpackage

`default_nettype wire

/* source/arch_regfile.sv */
// architectural register file
`timescale 1ns/1ps
`default_nettype none

module arch_regfile
   import commit_trace_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              we1,               // older write port
   input  logic [REG_AW-1:0] waddr1,
   input  logic [DATA_W-1:0] wdata1,
   input  logic              we2,               // younger write port
   input  logic [REG_AW-1:0] waddr2,
   input  logic [DATA_W-1:0] wdata2,
   input  logic [REG_AW-1:0] rf_raddr,          // debug read address
   output logic [DATA_W-1:0] rf_rdata           // debug read data, combinational
);

   localparam int NREG = 1 << REG_AW;           // 32 architectural registers

   // register 0 has no storage, it always reads zero
   logic [DATA_W-1:0] regs [1:NREG-1];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 1; i < NREG; i++)
            regs[i] <= '0;                      // all registers start at zero
      end
      else
      begin
         for (int i = 1; i < NREG; i++)
         begin
            // port 2 carries the younger instruction and wins a same-address clash
            if (we2 && (waddr2 == REG_AW'(i)))
               regs[i] <= wdata2;
            else if (we1 && (waddr1 == REG_AW'(i)))
               regs[i] <= wdata1;
         end
      end
   end

   always_comb
   begin
      if (rf_raddr == '0)
         rf_rdata = '0;                         // hardwired zero register
      else
         rf_rdata = regs[rf_raddr];
   end

endmodule

`default_nettype wire

/* source/commit_merge.sv */
// writeback slot merger
`timescale 1ns/1ps
`default_nettype none

module commit_merge
   import commit_trace_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              take,              // slots accepted this cycle
   input  wb_slot_t          wb_slot_1,         // older slot
   input  wb_slot_t          wb_slot_2,         // younger slot
   output logic              we1,
   output logic [REG_AW-1:0] waddr1,
   output logic [DATA_W-1:0] wdata1,
   output logic              we2,
   output logic [REG_AW-1:0] waddr2,
   output logic [DATA_W-1:0] wdata2,
   output logic              push_a,            // rec_a valid
   output logic              push_b,            // rec_b valid, only with push_a
   output trace_rec_t        rec_a,             // older record
   output trace_rec_t        rec_b              // younger record
);

   logic             q1;                        // slot 1 retires a register write
   logic             q2;                        // slot 2 retires a register write
   logic [SEQ_W-1:0] seq_cnt;                   // number of the next record
   logic [1:0]       n_push;                    // records pushed this cycle

   function automatic trace_rec_t make_rec(input wb_slot_t slot, input logic [SEQ_W-1:0] seq);
      trace_rec_t rec;
      rec.seq     = seq;
      rec.pc      = slot.pc;
      rec.rd_addr = slot.rd_addr;
      rec.dout    = slot.dout;
      return rec;
   endfunction

   assign q1 = take & wb_slot_1.valid & wb_slot_1.rd_we;
   assign q2 = take & wb_slot_2.valid & wb_slot_2.rd_we;

   // register write ports follow the slots one to one
   assign we1    = q1;
   assign waddr1 = wb_slot_1.rd_addr;
   assign wdata1 = wb_slot_1.dout;
   assign we2    = q2;
   assign waddr2 = wb_slot_2.rd_addr;
   assign wdata2 = wb_slot_2.dout;

   // compact the pair, a lone slot 2 goes out on the a lane
   assign push_a = q1 | q2;
   assign push_b = q1 & q2;
   assign rec_a  = q1 ? make_rec(wb_slot_1, seq_cnt) : make_rec(wb_slot_2, seq_cnt);
   assign rec_b  = make_rec(wb_slot_2, seq_cnt + SEQ_W'(1)); // b is always slot 2

   assign n_push = {1'b0, push_a} + {1'b0, push_b};

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         seq_cnt <= '0;
      else
         seq_cnt <= seq_cnt + SEQ_W'(n_push);   // one step per record, wraps
   end

endmodule

`default_nettype wire

/* source/trace_fifo.sv */
// trace record buffer
`timescale 1ns/1ps
`default_nettype none

module trace_fifo
   import commit_trace_pkg::*;
#(
   parameter int FIFO_DEPTH = 8                 // power of two, at least 4
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic                       push_a,   // write rec_a at the write pointer
   input  logic                       push_b,   // write rec_b at the entry after it
   input  trace_rec_t                 rec_a,
   input  trace_rec_t                 rec_b,
   input  logic                       pop,      // head leaves this cycle
   output trace_rec_t                 head,     // oldest record
   output logic [$clog2(FIFO_DEPTH):0] count    // occupancy
);

   localparam int AW = $clog2(FIFO_DEPTH);      // pointer width
   localparam int CW = AW + 1;                  // occupancy width

   trace_rec_t     mem [FIFO_DEPTH];            // record storage
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [AW-1:0]  wr_ptr_b;                    // slot for the younger record
   logic [1:0]     n_push;

   assign wr_ptr_b = wr_ptr + AW'(1);           // wraps with the power of two depth
   assign n_push   = {1'b0, push_a} + {1'b0, push_b};

   // payload store
   always_ff @(posedge clk)
   begin
      if (push_a)
         mem[wr_ptr] <= rec_a;
      if (push_b)
         mem[wr_ptr_b] <= rec_b;
   end

   // pointers and occupancy
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         wr_ptr <= wr_ptr + AW'(n_push);
         rd_ptr <= rd_ptr + AW'(pop);
         count  <= count + CW'(n_push) - CW'(pop); // pushes minus pop
      end
   end

   assign head = mem[rd_ptr];                   // read straight from storage

endmodule

`default_nettype wire

/* source/trace_ctrl.sv */
// trace port flow control
`timescale 1ns/1ps
`default_nettype none

module trace_ctrl
#(
   parameter int FIFO_DEPTH  = 8,               // buffer depth
   parameter int CREDIT_INIT = 4                // credits after reset, 1 to 15
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [$clog2(FIFO_DEPTH):0] count,   // buffer occupancy, registered
   input  logic                       credit_return, // one pulse, one credit back
   output logic                       take,     // slots accepted this cycle
   output logic                       wb_stall, // core holds its slots
   output logic                       pop,      // buffer head leaves
   output logic                       trace_valid // beat on the trace port
);

   localparam int CW  = $clog2(FIFO_DEPTH) + 1; // occupancy width
   localparam int CRW = $clog2(CREDIT_INIT + 1); // credit counter width

   logic [CRW-1:0] credits;                     // beats the consumer can still take
   logic           non_empty;
   logic           have_credit;

   // a full cycle needs two free entries, free = depth - count
   assign wb_stall = (count > CW'(FIFO_DEPTH - 2));
   assign take     = ~wb_stall;

   assign non_empty   = (count != '0);
   assign have_credit = (credits != '0);

   // no ready on the port, every valid cycle is a beat
   assign trace_valid = non_empty & have_credit;
   assign pop         = trace_valid;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         credits <= CRW'(CREDIT_INIT);
      else
      begin
         case ({trace_valid, credit_return})
            2'b10:   credits <= credits - CRW'(1); // beat consumes one
            2'b01:   credits <= credits + CRW'(1); // consumer freed one
            default: credits <= credits;        // both or neither, no change
         endcase
      end
   end

   // consumer never returns more than it received, so credits stay within CREDIT_INIT

endmodule

`default_nettype wire

/* source/commit_trace_top.sv */
// commit trace subsystem
`timescale 1ns/1ps
`default_nettype none

module commit_trace_top
   import commit_trace_pkg::*;
#(
   parameter int FIFO_DEPTH  = 8,               // trace buffer depth
   parameter int CREDIT_INIT = 4                // trace port credits
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  wb_slot_t          wb_slot_1,         // older writeback slot
   input  wb_slot_t          wb_slot_2,         // younger writeback slot
   output logic              wb_stall,
   output logic              trace_valid,
   output trace_rec_t        trace_rec,
   input  logic              credit_return,
   input  logic [REG_AW-1:0] rf_raddr,
   output logic [DATA_W-1:0] rf_rdata
);

   localparam int CW = $clog2(FIFO_DEPTH) + 1;  // occupancy width

   logic              take;
   logic              pop;
   logic [CW-1:0]     count;
   logic              we1;
   logic              we2;
   logic [REG_AW-1:0] waddr1;
   logic [REG_AW-1:0] waddr2;
   logic [DATA_W-1:0] wdata1;
   logic [DATA_W-1:0] wdata2;
   logic              push_a;
   logic              push_b;
   trace_rec_t        rec_a;
   trace_rec_t        rec_b;

   trace_ctrl #(.FIFO_DEPTH(FIFO_DEPTH), .CREDIT_INIT(CREDIT_INIT)) u_ctrl
   (
      .clk(clk), .rst_n(rst_n), .count(count), .credit_return(credit_return),
      .take(take), .wb_stall(wb_stall), .pop(pop), .trace_valid(trace_valid)
   );

   commit_merge u_merge
   (
      .clk(clk), .rst_n(rst_n), .take(take),
      .wb_slot_1(wb_slot_1), .wb_slot_2(wb_slot_2),
      .we1(we1), .waddr1(waddr1), .wdata1(wdata1),
      .we2(we2), .waddr2(waddr2), .wdata2(wdata2),
      .push_a(push_a), .push_b(push_b), .rec_a(rec_a), .rec_b(rec_b)
   );

   arch_regfile u_rf
   (
      .clk(clk), .rst_n(rst_n),
      .we1(we1), .waddr1(waddr1), .wdata1(wdata1),
      .we2(we2), .waddr2(waddr2), .wdata2(wdata2),
      .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
   );

   trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo
   (
      .clk(clk), .rst_n(rst_n),
      .push_a(push_a), .push_b(push_b), .rec_a(rec_a), .rec_b(rec_b),
      .pop(pop), .head(trace_rec), .count(count) // head feeds the port directly
   );

endmodule

`default_nettype wire

/* verification/trace_model.svh */
// commit trace reference model
`ifndef TRACE_MODEL_SVH
`define TRACE_MODEL_SVH

// a slot retires a register write only with both flags set
function automatic logic slot_writes(input wb_slot_t s);
   return s.valid & s.rd_we;
endfunction

// expected trace record for one retiring slot
function automatic trace_rec_t expect_rec(input wb_slot_t s, input logic [SEQ_W-1:0] seq);
   trace_rec_t r;
   r.seq     = seq;                             // running number, no gaps
   r.pc      = s.pc;
   r.rd_addr = s.rd_addr;
   r.dout    = s.dout;
   return r;
endfunction

// expected register value after one taken cycle
function automatic logic [DATA_W-1:0] expect_reg(input int idx,
                                                 input logic [DATA_W-1:0] cur,
                                                 input wb_slot_t s1,
                                                 input wb_slot_t s2);
   logic [DATA_W-1:0] v;
   v = cur;
   if (idx == 0)
      v = '0;                                   // zero register ignores writes
   else if (slot_writes(s2) && (s2.rd_addr == REG_AW'(idx)))
      v = s2.dout;                              // younger slot wins a clash
   else if (slot_writes(s1) && (s1.rd_addr == REG_AW'(idx)))
      v = s1.dout;
   return v;
endfunction

// build a slot from its fields
function automatic wb_slot_t slot_of(input logic v, input logic we,
                                     input logic [REG_AW-1:0] a,
                                     input logic [DATA_W-1:0] d,
                                     input logic [PC_W-1:0] pc);
   wb_slot_t s;
   s.valid   = v;
   s.rd_we   = we;
   s.rd_addr = a;
   s.dout    = d;
   s.pc      = pc;
   return s;
endfunction

`endif

/* verification/commit_trace_tb.sv */
// commit trace testbench
`timescale 1ns/1ps
`default_nettype none

module commit_trace_tb
   import commit_trace_pkg::*;
();

   localparam int FIFO_DEPTH  = 8;
   localparam int CREDIT_INIT = 4;
   localparam int NREG        = 32;
   localparam int TIMEOUT     = 400;            // cycles per wait loop

   logic              clk;
   logic              rst_n;
   wb_slot_t          wb_slot_1;
   wb_slot_t          wb_slot_2;
   logic              wb_stall;
   logic              trace_valid;
   trace_rec_t        trace_rec;
   logic              credit_return;
   logic [REG_AW-1:0] rf_raddr;
   logic [DATA_W-1:0] rf_rdata;

   trace_rec_t        exp_q [$];                // records still owed by the DUT
   logic [DATA_W-1:0] model_regs [NREG];
   logic [SEQ_W-1:0]  model_seq;                // number of the next record
   int                model_credits;
   logic              model_stall;              // expected wb_stall this cycle
   logic              model_valid;              // expected trace_valid this cycle
   int                owed;                     // beats not yet given back
   logic              consumer_on;
   int                data_errors;
   int                timeouts;
   int                beats;

   `include "trace_model.svh"

   commit_trace_top #(.FIFO_DEPTH(FIFO_DEPTH), .CREDIT_INIT(CREDIT_INIT)) commit_trace_top_inst
   (
      .clk(clk), .rst_n(rst_n), .wb_slot_1(wb_slot_1), .wb_slot_2(wb_slot_2),
      .wb_stall(wb_stall), .trace_valid(trace_valid), .trace_rec(trace_rec),
      .credit_return(credit_return), .rf_raddr(rf_raddr), .rf_rdata(rf_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                   // 40 ns period
   end

   // stall and port valid against the model occupancy and credits
   task automatic check_flow();
      model_stall = (exp_q.size() > FIFO_DEPTH - 2);
      model_valid = (exp_q.size() > 0) && (model_credits > 0);
      if (wb_stall !== model_stall)
      begin
         $display("[ERROR] %0t: wb_stall %b, expected %b", $time, wb_stall, model_stall);
         data_errors++;
      end
      if (trace_valid !== model_valid)
      begin
         $display("[ERROR] %0t: trace_valid %b, expected %b", $time, trace_valid, model_valid);
         data_errors++;
      end
   endtask

   task automatic check_beat();
      trace_rec_t exp;
      if (trace_valid)
      begin
         beats++;
         if (exp_q.size() == 0)
         begin
            $display("[ERROR] %0t: beat seq %0d with no record expected", $time, trace_rec.seq);
            data_errors++;
         end
         else
         begin
            exp = exp_q.pop_front();            // oldest outstanding record
            if (trace_rec !== exp)
            begin
               $display("[ERROR] %0t: beat seq %0d pc %h rd %0d val %h", $time,
                        trace_rec.seq, trace_rec.pc, trace_rec.rd_addr, trace_rec.dout);
               $display("[ERROR] %0t: expected seq %0d pc %h rd %0d val %h", $time,
                        exp.seq, exp.pc, exp.rd_addr, exp.dout);
               data_errors++;
            end
         end
      end
   endtask

   // slots presented now are taken on the coming edge
   task automatic record_cycle();
      wb_slot_t s1;
      wb_slot_t s2;
      s1 = wb_slot_1;
      s2 = wb_slot_2;
      if (!model_stall)
      begin
         if (slot_writes(s1))
         begin
            exp_q.push_back(expect_rec(s1, model_seq));
            model_seq = model_seq + SEQ_W'(1);
         end
         if (slot_writes(s2))
         begin
            exp_q.push_back(expect_rec(s2, model_seq)); // slot 2 always after slot 1
            model_seq = model_seq + SEQ_W'(1);
         end
         for (int i = 0; i < NREG; i++)
            model_regs[i] = expect_reg(i, model_regs[i], s1, s2);
      end
   endtask

   // compare process samples mid-cycle where all outputs are settled
   always @(negedge clk)
   begin
      if (rst_n)
      begin
         check_flow();
         check_beat();
         record_cycle();
         model_credits = model_credits - int'(model_valid) + int'(credit_return);
         owed          = owed + int'(trace_valid);
      end
   end

   // consumer hands credits back after random delays
   initial
   begin
      forever
      begin
         @(posedge clk);
         #2;
         credit_return = 1'b0;
         if (consumer_on && (owed > 0) && (($urandom % 3) == 0))
         begin
            credit_return = 1'b1;               // one pulse per credit
            owed--;
         end
      end
   end

   function automatic wb_slot_t random_slot();
      return slot_of((($urandom % 4) != 0), (($urandom % 4) != 0), REG_AW'($urandom),
                     $urandom, PC_W'($urandom));
   endfunction

   // present a pair and hold it until the edge that takes it
   task automatic issue(input wb_slot_t s1, input wb_slot_t s2);
      int waited;
      wb_slot_1 = s1;
      wb_slot_2 = s2;
      waited    = 0;
      @(negedge clk);
      while (wb_stall && (waited < TIMEOUT))
      begin
         waited++;
         @(negedge clk);
      end
      if (wb_stall)
      begin
         $display("timeout: writeback stall never cleared at %0t", $time);
         timeouts++;
      end
      @(posedge clk);
      #2;
   endtask

   task automatic idle(input int n);
      wb_slot_1 = '0;
      wb_slot_2 = '0;
      repeat (n)
      begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic random_traffic(input int n);
      wb_slot_t s1;
      wb_slot_t s2;
      for (int i = 0; i < n; i++)
      begin
         s1 = random_slot();
         s2 = random_slot();
         if (($urandom % 4) == 0)
            s2.rd_addr = s1.rd_addr;            // same destination now and then
         issue(s1, s2);
      end
   endtask

   task automatic wait_drain();
      int waited;
      waited = 0;
      while (((exp_q.size() != 0) || (owed != 0)) && (waited < TIMEOUT))
      begin
         @(posedge clk);
         #2;
         waited++;
      end
      if ((exp_q.size() != 0) || (owed != 0))
      begin
         $display("timeout: trace buffer did not drain, %0d records missing", exp_q.size());
         timeouts++;
      end
   endtask

   task automatic readback_regs();
      for (int i = 0; i < NREG; i++)
      begin
         rf_raddr = REG_AW'(i);
         @(negedge clk);
         if (rf_rdata !== model_regs[i])
         begin
            $display("[ERROR] %0t: register %0d reads %h, expected %h", $time, i,
                     rf_rdata, model_regs[i]);
            data_errors++;
         end
         @(posedge clk);
         #2;
      end
   endtask

   task automatic directed_cases();
      issue(slot_of(1'b1, 1'b1, 5'd5, 32'h1111_aaaa, 30'h100),
            slot_of(1'b1, 1'b1, 5'd5, 32'h2222_bbbb, 30'h101)); // clash on r5
      issue(slot_of(1'b1, 1'b0, 5'd6, 32'h3333_cccc, 30'h102),
            slot_of(1'b1, 1'b1, 5'd7, 32'h4444_dddd, 30'h103)); // lone slot 2
      issue(slot_of(1'b1, 1'b1, 5'd0, 32'hdead_beef, 30'h104),
            slot_of(1'b0, 1'b1, 5'd9, 32'h5555_eeee, 30'h105)); // r0 write with an empty slot 2
      issue(slot_of(1'b0, 1'b0, 5'd3, 32'h6666_ffff, 30'h106),
            slot_of(1'b1, 1'b1, 5'd0, 32'h7777_0000, 30'h107));
   endtask

   // hold credits back until the buffer stalls the core
   task automatic starve_credits();
      int waited;
      int start_beats;
      logic stalled;
      @(negedge clk);
      consumer_on = 1'b0;
      @(posedge clk);
      #2;
      start_beats = beats;
      waited  = 0;
      stalled = 1'b0;
      while (!stalled && (waited < TIMEOUT))
      begin
         wb_slot_1 = slot_of(1'b1, 1'b1, REG_AW'($urandom), $urandom, PC_W'($urandom));
         wb_slot_2 = slot_of(1'b1, 1'b1, REG_AW'($urandom), $urandom, PC_W'($urandom));
         @(negedge clk);
         stalled = wb_stall;
         if (!stalled)
         begin
            @(posedge clk);
            #2;
         end
         waited++;
      end
      if (!stalled)
      begin
         $display("timeout: wb_stall never rose without credits");
         timeouts++;
      end
      repeat (10) @(negedge clk);               // slots held and no beats expected
      if (beats - start_beats > CREDIT_INIT)
      begin
         $display("[ERROR] %0t: %0d beats without credit return, limit %0d", $time,
                  beats - start_beats, CREDIT_INIT);
         data_errors++;
      end
      consumer_on = 1'b1;
      @(posedge clk);
      #2;
      issue(wb_slot_1, wb_slot_2);              // held pair goes in once credits return
   endtask

   initial
   begin
      int unsigned seed;
      seed          = 32'hd077_e226;
      void'($urandom(seed));
      rst_n         = 1'b0;
      wb_slot_1     = '0;
      wb_slot_2     = '0;
      credit_return = 1'b0;
      rf_raddr      = '0;
      consumer_on   = 1'b1;
      model_seq     = '0;
      model_credits = CREDIT_INIT;
      model_stall   = 1'b0;
      model_valid   = 1'b0;
      owed          = 0;
      data_errors   = 0;
      timeouts      = 0;
      beats         = 0;
      for (int i = 0; i < NREG; i++)
         model_regs[i] = '0;
      repeat (3) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      if ((trace_valid !== 1'b0) || (wb_stall !== 1'b0))
      begin
         $display("[ERROR] %0t: after reset trace_valid %b wb_stall %b", $time,
                  trace_valid, wb_stall);
         data_errors++;
      end
      @(posedge clk);
      #2;
      readback_regs();                          // all zero after reset
      directed_cases();
      idle(4);
      wait_drain();
      readback_regs();
      random_traffic(300);
      idle(4);
      wait_drain();
      readback_regs();
      starve_credits();
      random_traffic(200);
      idle(4);
      wait_drain();
      readback_regs();
      $display("summary: %0d value errors, %0d timeouts, %0d beats, seed %0h",
               data_errors, timeouts, beats, seed);
      if ((data_errors == 0) && (timeouts == 0))
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verification
source/commit_trace_pkg.sv
source/arch_regfile.sv
source/commit_merge.sv
source/trace_fifo.sv
source/trace_ctrl.sv
source/commit_trace_top.sv
verification/commit_trace_tb.sv

/* run.sh */
#!/bin/sh
# build and run the commit trace testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module commit_trace_tb -o commit_trace_sim

out=$(./obj_dir/commit_trace_sim)
echo "$out"

# exit status follows the verdict line
echo "$out" | grep -q "RESULT: PASS"
